//--- common/input_pkg.sv
/*
 * Input section shared definitions
 * PS/2 event and scan code types, keyboard matrix types, joystick
 * bit positions and the reset sequencer states
 */
`default_nettype none

package input_pkg;

	// ====================
	// matrix geometry
	// ====================
	localparam int ROW_COUNT    = 8; // rows, and columns per row
	localparam int ALPHA_ROW    = 4; // alpha lock returns here
	localparam int ALPHA_STROBE = 8; // strobe line for alpha lock

	localparam logic [7:0] CAPS_CODE = 8'h58; // set-2 caps lock

	typedef logic [8:0] scan_code_t; // bit 8 is the E0 prefix
	typedef logic [7:0] key_row_t; // bit index = column
	typedef key_row_t [ROW_COUNT-1:0] key_matrix_t; // 1 = key held
	typedef logic [8:0] col_select_t; // active low strobes
	typedef logic [7:0] hold_count_t;

	typedef struct packed {
		logic       toggle; // flips once per event
		logic       pressed;
		scan_code_t code;
	} ps2_event_t;

	// ====================
	// joystick
	// ====================
	typedef logic [11:0] joy_t;

	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE  = 4;
	localparam int JOY_FIRE2 = 5;
	localparam int JOY_BTN1  = 6;
	localparam int JOY_BTN2  = 7;
	localparam int JOY_BTN3  = 8;
	localparam int JOY_ENTER = 9;
	localparam int JOY_BTN8  = 10;
	localparam int JOY_BTN9  = 11;

	// reset phases
	typedef enum logic [1:0] {
		WAIT_LOAD,
		LOADING,
		SETTLE,
		RUN
	} reset_state_t;

endpackage

`default_nettype wire

//--- source/hold_timer.sv
/*
 * Hold timer
 * Reloadable countdown, busy while nonzero
 */
`timescale 1ns/1ps
`default_nettype none

module hold_timer
	import input_pkg::*;
#(
	parameter int HOLD_CYCLES = 255
) (
	input  logic CLK_50M,
	input  logic rst_i,
	input  logic load_i,
	output logic busy_o
);

	localparam hold_count_t LOAD_VALUE = hold_count_t'(HOLD_CYCLES);

	hold_count_t count_q;

	always_ff @(posedge CLK_50M) begin
		if (rst_i) begin
			count_q <= '0;
		end else if (load_i) begin
			count_q <= LOAD_VALUE; // keeps reloading while held
		end else if (count_q != '0) begin
			count_q <= count_q - hold_count_t'(1);
		end
	end

	assign busy_o = (count_q != '0);

endmodule

`default_nettype wire

//--- source/reset_sequencer.sv
/*
 * Machine reset sequencer
 * Holds the console in reset until the first image download, then
 * flags loading for a fixed settle time after each download or reset
 */
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer
	import input_pkg::*;
#(
	parameter int HOLD_CYCLES = 255
) (
	input  logic CLK_50M,
	input  logic rst_i,
	input  logic download_i,
	input  logic reset_req_i,
	output logic machine_reset_o,
	output logic loading_o
);

	reset_state_t state_q;
	reset_state_t state_d;
	logic         timer_load;
	logic         timer_busy;

	assign timer_load = download_i | reset_req_i;

	// state register costs one cycle, so the timer runs one short
	hold_timer #(
		.HOLD_CYCLES(HOLD_CYCLES - 1)
	) i_hold_timer (
		.CLK_50M(CLK_50M),
		.rst_i  (rst_i),
		.load_i (timer_load),
		.busy_o (timer_busy)
	);

	// ====================
	// state machine
	// ====================
	always_comb begin
		state_d = state_q;
		case (state_q)
			WAIT_LOAD: if (download_i) state_d = LOADING;
			LOADING:   if (!download_i) state_d = SETTLE;
			SETTLE: begin
				if (download_i) state_d = LOADING;
				else if (!reset_req_i && !timer_busy) state_d = RUN;
			end
			RUN: begin
				if (download_i) state_d = LOADING;
				else if (reset_req_i) state_d = SETTLE;
			end
			default: state_d = WAIT_LOAD;
		endcase
	end

	always_ff @(posedge CLK_50M) begin
		if (rst_i) begin
			state_q <= WAIT_LOAD;
		end else begin
			state_q <= state_d;
		end
	end

	assign machine_reset_o = (state_q == WAIT_LOAD) | (state_q == LOADING) | reset_req_i;

	// loading waits for a reset request to end, so it never overlaps reset outside LOADING
	assign loading_o = (state_q == LOADING) | ((state_q == SETTLE) & ~reset_req_i);

endmodule

`default_nettype wire

//--- source/joystick_mapper.sv
/*
 * Joystick mapper
 * Applies the player swap and folds both sticks into a key matrix
 * overlay: directions and fire on columns 1 and 0, buttons on keys
 */
`timescale 1ns/1ps
`default_nettype none

module joystick_mapper
	import input_pkg::*;
(
	input  joy_t        joy0_i,
	input  joy_t        joy1_i,
	input  logic        joy_swap_i,
	output key_matrix_t keys_o
);

	joy_t player_a;
	joy_t player_b;
	joy_t either;

	assign player_a = joy_swap_i ? joy1_i : joy0_i;
	assign player_b = joy_swap_i ? joy0_i : joy1_i;
	assign either   = joy0_i | joy1_i; // buttons are shared

	always_comb begin
		keys_o = '0;

		// ====================
		// player A on column 1
		// ====================
		keys_o[0][1] = player_a[JOY_FIRE] | player_b[JOY_FIRE2]; // crossed fire 2
		keys_o[1][1] = player_a[JOY_LEFT];
		keys_o[2][1] = player_a[JOY_RIGHT];
		keys_o[3][1] = player_a[JOY_DOWN];
		keys_o[4][1] = player_a[JOY_UP];

		// player B on column 0
		keys_o[0][0] = player_b[JOY_FIRE] | player_a[JOY_FIRE2];
		keys_o[1][0] = player_b[JOY_LEFT];
		keys_o[2][0] = player_b[JOY_RIGHT];
		keys_o[3][0] = player_b[JOY_DOWN];
		keys_o[4][0] = player_b[JOY_UP];

		// ====================
		// buttons
		// ====================
		keys_o[4][2] = either[JOY_BTN1]; // key 1
		keys_o[4][6] = either[JOY_BTN2]; // key 2
		keys_o[4][5] = either[JOY_BTN3]; // key 3
		keys_o[2][7] = either[JOY_ENTER];
		keys_o[3][5] = either[JOY_BTN8]; // key 8
		keys_o[3][6] = either[JOY_BTN9]; // key 9

		// 8 and 9 also press fn, for menus that want fn+digit
		keys_o[4][7] = either[JOY_BTN8] | either[JOY_BTN9];
	end

endmodule

`default_nettype wire

//--- keyboard/ps2_key_decoder.sv
/*
 * PS/2 key decoder
 * Turns set-2 key events into held bits of the console key matrix
 * and keeps the caps lock driven alpha lock
 */
`timescale 1ns/1ps
`default_nettype none

module ps2_key_decoder
	import input_pkg::*;
(
	input  logic        CLK_50M,
	input  logic        rst_i,
	input  ps2_event_t  ps2_i,
	output key_matrix_t keys_o,
	output logic        alpha_lock_o
);

	typedef struct packed {
		logic       hit;
		logic [2:0] row;
		logic [2:0] col;
	} key_pos_t;

	function automatic key_pos_t at(input logic [2:0] row, input logic [2:0] col);
		key_pos_t pos;
		pos.hit = 1'b1;
		pos.row = row;
		pos.col = col;
		return pos;
	endfunction

	logic        toggle_q;
	logic        new_event;
	key_pos_t    pos;
	key_matrix_t keys_q;
	logic        alpha_q;

	assign new_event = (ps2_i.toggle != toggle_q);

	// ====================
	// code lookup
	// ====================
	always_comb begin
		case (ps2_i.code[7:0]) // E0 prefix ignored
			8'h4E, 8'h55, 8'h5D: pos = at(3'd0, 3'd7); // - = \ all give =
			8'h49: pos = at(3'd0, 3'd6);
			8'h41: pos = at(3'd0, 3'd5);
			8'h3A: pos = at(3'd0, 3'd4); // m
			8'h31: pos = at(3'd0, 3'd3); // n
			8'h54: pos = at(3'd0, 3'd2); // [ gives /
			8'h0E: pos = at(3'd0, 3'd1); // backquote is fire
			8'h29: pos = at(3'd1, 3'd7); // space
			8'h4B: pos = at(3'd1, 3'd6);
			8'h42: pos = at(3'd1, 3'd5);
			8'h3B: pos = at(3'd1, 3'd4);
			8'h33: pos = at(3'd1, 3'd3);
			8'h4C: pos = at(3'd1, 3'd2); // ;
			8'h6B: pos = at(3'd1, 3'd1); // left
			8'h5A: pos = at(3'd2, 3'd7); // enter
			8'h44: pos = at(3'd2, 3'd6);
			8'h43: pos = at(3'd2, 3'd5);
			8'h3C: pos = at(3'd2, 3'd4);
			8'h35: pos = at(3'd2, 3'd3);
			8'h4D: pos = at(3'd2, 3'd2);
			8'h74: pos = at(3'd2, 3'd1); // right
			8'h46: pos = at(3'd3, 3'd6); // 9
			8'h3E: pos = at(3'd3, 3'd5);
			8'h3D: pos = at(3'd3, 3'd4);
			8'h36: pos = at(3'd3, 3'd3);
			8'h45: pos = at(3'd3, 3'd2); // 0
			8'h72: pos = at(3'd3, 3'd1); // down
			8'h11: pos = at(3'd4, 3'd7); // left alt is fn
			8'h1E: pos = at(3'd4, 3'd6); // 2
			8'h26: pos = at(3'd4, 3'd5);
			8'h25: pos = at(3'd4, 3'd4);
			8'h2E: pos = at(3'd4, 3'd3);
			8'h16: pos = at(3'd4, 3'd2); // 1
			8'h75: pos = at(3'd4, 3'd1); // up
			8'h12, 8'h59: pos = at(3'd5, 3'd7); // both shifts
			8'h1B: pos = at(3'd5, 3'd6);
			8'h23: pos = at(3'd5, 3'd5);
			8'h2B: pos = at(3'd5, 3'd4);
			8'h34: pos = at(3'd5, 3'd3);
			8'h1C: pos = at(3'd5, 3'd2); // a
			8'h14: pos = at(3'd6, 3'd7); // ctrl
			8'h1D: pos = at(3'd6, 3'd6);
			8'h24: pos = at(3'd6, 3'd5);
			8'h2D: pos = at(3'd6, 3'd4);
			8'h2C: pos = at(3'd6, 3'd3);
			8'h15: pos = at(3'd6, 3'd2); // q
			8'h22: pos = at(3'd7, 3'd6); // x
			8'h21: pos = at(3'd7, 3'd5);
			8'h2A: pos = at(3'd7, 3'd4);
			8'h32: pos = at(3'd7, 3'd3);
			8'h1A: pos = at(3'd7, 3'd2); // z
			default: pos = '0; // unknown code, no change
		endcase
	end

	always_ff @(posedge CLK_50M) begin
		if (rst_i) begin
			toggle_q <= ps2_i.toggle; // no phantom event out of reset
			keys_q   <= '0;
			alpha_q  <= 1'b0;
		end else begin
			toggle_q <= ps2_i.toggle;
			if (new_event) begin
				if (ps2_i.code[7:0] == CAPS_CODE) begin
					if (ps2_i.pressed) alpha_q <= ~alpha_q; // release ignored
				end else if (pos.hit) begin
					keys_q[pos.row][pos.col] <= ps2_i.pressed;
				end
			end
		end
	end

	assign keys_o       = keys_q;
	assign alpha_lock_o = alpha_q;

endmodule

`default_nettype wire

//--- keyboard/key_matrix.sv
/*
 * Key matrix
 * Answers the console column strobes with active-low row returns,
 * merging keyboard and joystick keys and the alpha lock line
 */
`timescale 1ns/1ps
`default_nettype none

module key_matrix
	import input_pkg::*;
(
	input  key_matrix_t kbd_keys_i,
	input  key_matrix_t joy_keys_i,
	input  logic        alpha_lock_i,
	input  col_select_t col_select_i,
	output key_row_t    rows_o
);

	key_row_t    active_cols;
	key_matrix_t held;
	logic        alpha_active;

	// strobes 4..7 run in reverse order on the console side
	assign active_cols = ~{col_select_i[4], col_select_i[5], col_select_i[6],
		col_select_i[7], col_select_i[3:0]};

	assign held         = kbd_keys_i | joy_keys_i;
	assign alpha_active = alpha_lock_i & ~col_select_i[ALPHA_STROBE];

	// ====================
	// row returns
	// ====================
	always_comb begin
		for (int r = 0; r < ROW_COUNT; r++) begin
			rows_o[r] = ~(|(held[r] & active_cols));
		end
		if (alpha_active) rows_o[ALPHA_ROW] = 1'b0; // alpha lock pulls its row low
	end

endmodule

`default_nettype wire

//--- source/ti_input_top.sv
/*
 * Input and reset section top
 * Connects the PS/2 keyboard path, the joystick overlay, the
 * key matrix and the machine reset sequencer
 */
`timescale 1ns/1ps
`default_nettype none

module ti_input_top
	import input_pkg::*;
#(
	parameter int HOLD_CYCLES = 255
) (
	input  logic        CLK_50M,
	input  logic        rst_i,
	input  ps2_event_t  ps2_i,
	input  joy_t        joy0_i,
	input  joy_t        joy1_i,
	input  logic        joy_swap_i,
	input  col_select_t col_select_i,
	input  logic        download_i,
	input  logic        reset_req_i,
	output key_row_t    rows_o,
	output logic        machine_reset_o,
	output logic        loading_o
);

	key_matrix_t kbd_keys;
	key_matrix_t joy_keys;
	logic        alpha_lock;

	// ====================
	// keyboard path
	// ====================
	ps2_key_decoder i_ps2_key_decoder (
		.CLK_50M     (CLK_50M),
		.rst_i       (rst_i),
		.ps2_i       (ps2_i),
		.keys_o      (kbd_keys),
		.alpha_lock_o(alpha_lock)
	);

	joystick_mapper i_joystick_mapper (
		.joy0_i    (joy0_i),
		.joy1_i    (joy1_i),
		.joy_swap_i(joy_swap_i),
		.keys_o    (joy_keys)
	);

	key_matrix i_key_matrix (
		.kbd_keys_i  (kbd_keys),
		.joy_keys_i  (joy_keys),
		.alpha_lock_i(alpha_lock),
		.col_select_i(col_select_i),
		.rows_o      (rows_o)
	);

	// reset path
	reset_sequencer #(
		.HOLD_CYCLES(HOLD_CYCLES)
	) i_reset_sequencer (
		.CLK_50M        (CLK_50M),
		.rst_i          (rst_i),
		.download_i     (download_i),
		.reset_req_i    (reset_req_i),
		.machine_reset_o(machine_reset_o),
		.loading_o      (loading_o)
	);

endmodule

`default_nettype wire

//--- verification/ti_input_properties.sv
/*
 * Top-level properties
 * Idle strobes, reset and loading overlap, reset request follow
 */
`timescale 1ns/1ps
`default_nettype none

module ti_input_properties
	import input_pkg::*;
(
	input logic         CLK_50M,
	input logic         rst_i,
	input col_select_t  col_select_i,
	input key_row_t     rows_o,
	input logic         reset_req_i,
	input logic         machine_reset_o,
	input logic         loading_o,
	input reset_state_t state_i
);

	// alpha strobe is part of the all-ones pattern, so nothing can pull a row
	idle_rows_high: assert property (@(posedge CLK_50M) disable iff (rst_i)
		(col_select_i == '1) |-> (rows_o == '1))
		else $error("rows_o not all ones with every strobe off");

	no_reset_loading_overlap: assert property (@(posedge CLK_50M) disable iff (rst_i)
		(state_i != LOADING) |-> !(loading_o && machine_reset_o))
		else $error("loading_o and machine_reset_o both high outside LOADING");

	reset_follows_request: assert property (@(posedge CLK_50M) disable iff (rst_i)
		reset_req_i |-> machine_reset_o)
		else $error("machine_reset_o low during a reset request");

endmodule

`default_nettype wire

//--- verification/tb_ti_input.sv
/*
 * Input section testbench
 * Random key, joystick and reset stimulus checked against a model
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ti_input
	import input_pkg::*;
();

	localparam int HOLD = 20;

	// set-2 codes per row, column 7 down to column 0, 00 = no key
	localparam logic [63:0] CODE_ROW [8] = '{
		64'h55_49_41_3A_31_54_0E_00,
		64'h29_4B_42_3B_33_4C_6B_00,
		64'h5A_44_43_3C_35_4D_74_00,
		64'h00_46_3E_3D_36_45_72_00,
		64'h11_1E_26_25_2E_16_75_00,
		64'h12_1B_23_2B_34_1C_00_00,
		64'h14_1D_24_2D_2C_15_00_00,
		64'h00_22_21_2A_32_1A_00_00
	};

	logic        CLK_50M = 1'b0;
	logic        rst_i;
	ps2_event_t  ps2_i;
	joy_t        joy0_i;
	joy_t        joy1_i;
	logic        joy_swap_i;
	col_select_t col_select_i;
	logic        download_i;
	logic        reset_req_i;
	key_row_t    rows_o;
	logic        machine_reset_o;
	logic        loading_o;

	key_matrix_t mkeys; // model key state
	logic        malpha;
	integer      seed = 32'h4cd476dc;
	int          checks = 0;
	int          errors = 0;
	int          test_errors = 0;

	always #10 CLK_50M = ~CLK_50M;

	ti_input_top #(
		.HOLD_CYCLES(HOLD)
	) i_ti_input_top (
		.CLK_50M        (CLK_50M),
		.rst_i          (rst_i),
		.ps2_i          (ps2_i),
		.joy0_i         (joy0_i),
		.joy1_i         (joy1_i),
		.joy_swap_i     (joy_swap_i),
		.col_select_i   (col_select_i),
		.download_i     (download_i),
		.reset_req_i    (reset_req_i),
		.rows_o         (rows_o),
		.machine_reset_o(machine_reset_o),
		.loading_o      (loading_o)
	);

	bind ti_input_top ti_input_properties i_ti_input_properties (
		.CLK_50M        (CLK_50M),
		.rst_i          (rst_i),
		.col_select_i   (col_select_i),
		.rows_o         (rows_o),
		.reset_req_i    (reset_req_i),
		.machine_reset_o(machine_reset_o),
		.loading_o      (loading_o),
		.state_i        (i_reset_sequencer.state_q)
	);

	// ====================
	// model
	// ====================
	function automatic int model_slot(input logic [7:0] code);
		if (code == 8'h4E || code == 8'h5D) return 7; // minus, backslash alias equals
		if (code == 8'h59) return 47; // right shift
		for (int i = 0; i < 64; i++) begin
			if (code != 8'h00 && CODE_ROW[i / 8][(i % 8) * 8 +: 8] == code) return i;
		end
		return -1;
	endfunction

	function automatic key_matrix_t model_joy();
		key_matrix_t m;
		joy_t        a;
		joy_t        b;
		joy_t        any;
		m   = '0;
		a   = joy_swap_i ? joy1_i : joy0_i;
		b   = joy_swap_i ? joy0_i : joy1_i;
		any = joy0_i | joy1_i;
		m[0][1] = a[4] | b[5]; // fire or crossed fire 2
		m[0][0] = b[4] | a[5];
		m[1][1] = a[1];
		m[1][0] = b[1];
		m[2][1] = a[0];
		m[2][0] = b[0];
		m[3][1] = a[2];
		m[3][0] = b[2];
		m[4][1] = a[3];
		m[4][0] = b[3];
		m[4][2] = any[6];
		m[4][6] = any[7];
		m[4][5] = any[8];
		m[2][7] = any[9];
		m[3][5] = any[10];
		m[3][6] = any[11];
		m[4][7] = any[10] | any[11]; // fn
		return m;
	endfunction

	// pattern 0..8 drives one strobe low, 9 leaves all off
	function automatic key_row_t expected_rows(input int p);
		key_row_t    rows;
		key_matrix_t held;
		int          col;
		held = mkeys | model_joy();
		rows = '1;
		if (p < 8) begin
			col = (p < 4) ? p : 11 - p; // strobes 4..7 reversed
			for (int r = 0; r < 8; r++) begin
				if (held[r][col]) rows[r] = 1'b0;
			end
		end else if (p == 8 && malpha) begin
			rows[4] = 1'b0;
		end
		return rows;
	endfunction

	// ====================
	// helpers
	// ====================
	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			$display("ERROR %s expected %h got %h", name, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	task automatic report_fault(input string msg);
		$display("%s", msg);
		errors++;
		test_errors++;
	endtask

	task automatic end_test(input string name);
		$display("test %-8s done, %0d errors", name, test_errors);
		test_errors = 0;
	endtask

	task automatic drive_edge();
		@(posedge CLK_50M);
		#2;
	endtask

	task automatic scan_rows();
		for (int p = 0; p < 10; p++) begin
			drive_edge();
			col_select_i = (p < 9) ? ~(9'h001 << p) : 9'h1FF;
			@(negedge CLK_50M);
			check_value($sformatf("rows_o[pattern %0d]", p), expected_rows(p), rows_o);
		end
	endtask

	task automatic send_key(input logic [8:0] code, input logic pressed);
		int slot;
		drive_edge();
		ps2_i.code    = code;
		ps2_i.pressed = pressed;
		ps2_i.toggle  = ~ps2_i.toggle;
		if (code[7:0] == 8'h58) begin
			if (pressed) malpha = ~malpha; // caps release ignored
		end else begin
			slot = model_slot(code[7:0]);
			if (slot >= 0) mkeys[slot / 8][slot % 8] = pressed;
		end
		@(posedge CLK_50M); // keep events two cycles apart
	endtask

	task automatic measure_loading(output int n);
		n = 0;
		@(negedge CLK_50M);
		while (loading_o && n < 4 * HOLD) begin
			n++;
			@(negedge CLK_50M);
		end
		if (n >= 4 * HOLD) report_fault("timeout: loading_o stayed high");
	endtask

	// ====================
	// test sequence
	// ====================
	initial begin
		logic [31:0] rnd;
		logic [7:0]  code;
		int          n;
		int          guard;
		rst_i = 1'b1;
		ps2_i = '0;
		joy0_i = '0;
		joy1_i = '0;
		joy_swap_i = 1'b0;
		col_select_i = '1;
		download_i = 1'b0;
		reset_req_i = 1'b0;
		mkeys = '0;
		malpha = 1'b0;
		repeat (3) @(posedge CLK_50M);
		#2;
		rst_i = 1'b0;

		@(negedge CLK_50M);
		check_value("machine_reset_o", 1, machine_reset_o);
		check_value("loading_o", 0, loading_o);
		scan_rows();
		end_test("reset");

		repeat (200) begin
			rnd = $random(seed);
			case (rnd[1:0])
				2'd0, 2'd1: begin
					code = 8'h00;
					while (code == 8'h00) begin
						rnd[31:26] = 6'($random(seed));
						code = CODE_ROW[rnd[31:29]][rnd[28:26] * 8 +: 8];
					end
				end
				2'd2: code = rnd[3] ? 8'h59 : (rnd[4] ? 8'h4E : 8'h5D); // aliases
				default: code = rnd[15:8]; // mostly unknown
			endcase
			send_key({rnd[5], code}, rnd[6]); // bit 5 adds the E0 prefix
			scan_rows();
		end
		end_test("keys");

		repeat (4) begin
			send_key(9'h058, 1'b1);
			scan_rows();
			send_key(9'h058, 1'b0);
			scan_rows();
		end
		end_test("alpha");

		for (int i = 0; i < 64; i++) begin
			if (mkeys[i / 8][i % 8]) send_key({1'b0, CODE_ROW[i / 8][(i % 8) * 8 +: 8]}, 1'b0);
		end
		repeat (100) begin
			rnd = $random(seed);
			drive_edge();
			joy0_i = rnd[11:0];
			joy1_i = rnd[23:12];
			joy_swap_i = rnd[24];
			scan_rows();
		end
		drive_edge();
		joy0_i = '0;
		joy1_i = '0;
		end_test("joystick");

		check_value("machine_reset_o", 1, machine_reset_o);
		check_value("loading_o", 0, loading_o);
		drive_edge();
		download_i = 1'b1;
		guard = 0;
		@(negedge CLK_50M);
		while (!loading_o && guard < 10) begin
			guard++;
			@(negedge CLK_50M);
		end
		if (!loading_o) report_fault("timeout: loading_o did not rise after download");
		check_value("machine_reset_o", 1, machine_reset_o);
		repeat (5) drive_edge();
		download_i = 1'b0;
		measure_loading(n);
		check_value("loading_o cycles after download", HOLD, n);
		check_value("machine_reset_o", 0, machine_reset_o);

		drive_edge();
		reset_req_i = 1'b1;
		repeat (3) begin
			@(negedge CLK_50M);
			check_value("machine_reset_o", 1, machine_reset_o);
		end
		drive_edge();
		reset_req_i = 1'b0;
		measure_loading(n);
		check_value("loading_o cycles after reset request", HOLD, n);
		check_value("machine_reset_o", 0, machine_reset_o);
		end_test("sequence");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// run limit
	initial begin
		#1_000_000;
		$display("timeout: simulation did not reach its end");
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
common/input_pkg.sv
source/hold_timer.sv
source/reset_sequencer.sv
source/joystick_mapper.sv
keyboard/ps2_key_decoder.sv
keyboard/key_matrix.sv
source/ti_input_top.sv
verification/ti_input_properties.sv
verification/tb_ti_input.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the input section testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_ti_input -f compile.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
	exit 0
fi
exit 1
